/* dma_pkg.sv */
package dma_pkg;

	// Bus field widths
	typedef logic [31:0] bus_addr_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [3:0]  bus_did_t;
	typedef logic [3:0]  burst_len_t;
	typedef logic [1:0]  bus_mode_t;

	// Register bus and engine widths
	typedef logic [2:0]  reg_addr_t;
	typedef logic [15:0] xfer_len_t;
	typedef logic [4:0]  fifo_cnt_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_DRAIN
	} ctrl_state_t;

	// Request codes
	localparam bus_mode_t MODE_READ = 2'b01;

	// Ids this engine sends and accepts
	localparam bus_did_t DMA_DID    = 4'h2;
	localparam bus_did_t DMA_SUBDID = 4'h1;

	localparam int FIFO_DEPTH   = 16;
	localparam int MAX_BURST    = 8;
	localparam int CREDITS_INIT = 4;

	// Register map
	localparam reg_addr_t REG_ADDR   = 3'd0;
	localparam reg_addr_t REG_LEN    = 3'd1;
	localparam reg_addr_t REG_CTRL   = 3'd2;
	localparam reg_addr_t REG_STATUS = 3'd3;
	localparam reg_addr_t REG_DATA   = 3'd4;

	// Status word layout
	localparam int STATUS_CNT_LSB = 8;
	localparam int STATUS_REM_LSB = 16;

endpackage

/* fsab_req_if.sv */
`timescale 1ns/100ps

interface fsab_req_if;

	logic                  valid;
	dma_pkg::bus_mode_t    mode;
	dma_pkg::bus_did_t     did;
	dma_pkg::bus_did_t     subdid;
	dma_pkg::bus_addr_t    addr;
	dma_pkg::burst_len_t   len;

	modport ctrl (
		output valid,
		output mode,
		output did,
		output subdid,
		output addr,
		output len
	);

	modport top (
		input valid,
		input mode,
		input did,
		input subdid,
		input addr,
		input len
	);

endinterface

/* dma_regs.sv */
`timescale 1ns/100ps

module dma_regs (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                reg_valid,
	input  logic                reg_write,
	input  dma_pkg::reg_addr_t  reg_addr,
	input  dma_pkg::bus_data_t  reg_wdata,
	input  logic                busy,
	input  dma_pkg::xfer_len_t  remaining,
	input  dma_pkg::fifo_cnt_t  fifo_count,
	input  dma_pkg::bus_data_t  fifo_rdata,
	output dma_pkg::bus_data_t  reg_rdata,
	output logic                reg_rvalid,
	output dma_pkg::bus_addr_t  start_addr,
	output dma_pkg::xfer_len_t  start_len,
	output logic                start,
	output logic                fifo_pop
);

	logic               wr_en;
	logic               rd_en;
	dma_pkg::bus_data_t status_word;
	dma_pkg::bus_data_t rd_mux;

	assign wr_en = reg_valid && reg_write;
	assign rd_en = reg_valid && !reg_write;

	// Pop only when there is a word to hand out
	assign fifo_pop = rd_en && (reg_addr == dma_pkg::REG_DATA) && (fifo_count != '0);

	always_comb
	begin
		status_word = '0;
		status_word[0] = busy;
		status_word[dma_pkg::STATUS_CNT_LSB +: $bits(fifo_count)] = fifo_count;
		status_word[dma_pkg::STATUS_REM_LSB +: $bits(remaining)] = remaining;
		case (reg_addr)
			dma_pkg::REG_ADDR:   rd_mux = dma_pkg::bus_data_t'(start_addr);
			dma_pkg::REG_LEN:    rd_mux = dma_pkg::bus_data_t'(start_len);
			dma_pkg::REG_CTRL:   rd_mux = dma_pkg::bus_data_t'(busy);
			dma_pkg::REG_STATUS: rd_mux = status_word;
			dma_pkg::REG_DATA:   rd_mux = fifo_pop ? fifo_rdata : '0;
			default:             rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			start_addr <= '0;
			start_len  <= '0;
			start      <= 1'b0;
			reg_rvalid <= 1'b0;
		end
		else
		begin
			reg_rvalid <= rd_en;
			if (wr_en && reg_addr == dma_pkg::REG_ADDR)
				start_addr <= reg_wdata[$bits(start_addr)-1:0];
			if (wr_en && reg_addr == dma_pkg::REG_LEN)
				start_len <= reg_wdata[$bits(start_len)-1:0];
			// Start while already running is dropped
			start <= wr_en && (reg_addr == dma_pkg::REG_CTRL) && reg_wdata[0] && !busy && !start;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_en)
			reg_rdata <= rd_mux;
	end

	// Data read of an empty FIFO answers next cycle with zero
	a_rvalid_timing: assert property (@(posedge clk) disable iff (!arst_n)
		(rd_en && reg_addr == dma_pkg::REG_DATA && fifo_count == '0) |=>
			(reg_rvalid && reg_rdata == '0))
		else $error("empty data read not answered with zero one cycle later");

endmodule

/* dma_read_ctrl.sv */
`timescale 1ns/100ps

module dma_read_ctrl (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  dma_pkg::bus_addr_t  start_addr,
	input  dma_pkg::xfer_len_t  start_len,
	input  logic                fsabo_credit,
	input  logic                fsabi_valid,
	input  dma_pkg::bus_did_t   fsabi_did,
	input  dma_pkg::bus_did_t   fsabi_subdid,
	input  dma_pkg::bus_data_t  fsabi_data,
	input  dma_pkg::fifo_cnt_t  fifo_count,
	fsab_req_if.ctrl            req,
	output logic                busy,
	output dma_pkg::xfer_len_t  remaining,
	output logic                fifo_push,
	output dma_pkg::bus_data_t  fifo_wdata
);

	dma_pkg::ctrl_state_t state;
	dma_pkg::bus_addr_t   addr_q;
	dma_pkg::fifo_cnt_t   outstanding;
	dma_pkg::burst_len_t  next_burst;
	logic [2:0]           credits;
	logic [5:0]           space_need;
	logic                 issue;

	assign next_burst = (remaining < dma_pkg::xfer_len_t'(dma_pkg::MAX_BURST)) ?
		dma_pkg::burst_len_t'(remaining) : dma_pkg::burst_len_t'(dma_pkg::MAX_BURST);

	// Words already in the FIFO or still in flight hold their slots
	assign space_need = 6'(fifo_count) + 6'(outstanding) + 6'(next_burst);

	assign issue = (state == dma_pkg::ST_ISSUE) && (credits != '0) && (remaining != '0) &&
		(space_need <= 6'(dma_pkg::FIFO_DEPTH));

	assign fifo_push  = fsabi_valid && (fsabi_did == dma_pkg::DMA_DID) &&
		(fsabi_subdid == dma_pkg::DMA_SUBDID);
	assign fifo_wdata = fsabi_data;
	assign busy       = (state != dma_pkg::ST_IDLE);

	assign req.mode   = dma_pkg::MODE_READ;
	assign req.did    = dma_pkg::DMA_DID;
	assign req.subdid = dma_pkg::DMA_SUBDID;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state       <= dma_pkg::ST_IDLE;
			addr_q      <= '0;
			remaining   <= '0;
			credits     <= 3'(dma_pkg::CREDITS_INIT);
			outstanding <= '0;
			req.valid   <= 1'b0;
		end
		else
		begin
			req.valid   <= issue;
			credits     <= credits + 3'(fsabo_credit) - 3'(issue);
			outstanding <= outstanding + (issue ? 5'(next_burst) : 5'd0) - 5'(fifo_push);
			case (state)
				dma_pkg::ST_IDLE:
					if (start)
					begin
						addr_q    <= start_addr;
						remaining <= start_len;
						state     <= dma_pkg::ST_ISSUE;
					end
				dma_pkg::ST_ISSUE:
					if (issue)
					begin
						addr_q    <= addr_q + dma_pkg::bus_addr_t'(next_burst);
						remaining <= remaining - dma_pkg::xfer_len_t'(next_burst);
						if (remaining == dma_pkg::xfer_len_t'(next_burst))
							state <= dma_pkg::ST_DRAIN;
					end
					else if (remaining == '0)
						state <= dma_pkg::ST_DRAIN;
				dma_pkg::ST_DRAIN:
					if (outstanding == '0)
						state <= dma_pkg::ST_IDLE;
				default:
					state <= dma_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			req.addr <= addr_q;
			req.len  <= next_burst;
		end
	end

	a_credit_used: assert property (@(posedge clk) disable iff (!arst_n)
		req.valid |-> $past(credits) != '0)
		else $error("request sent without a credit");

	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= 3'(dma_pkg::CREDITS_INIT))
		else $error("credit counter above initial grant");

	a_push_expected: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_push |-> outstanding != '0)
		else $error("response word with nothing outstanding");

endmodule

/* dma_data_fifo.sv */
`timescale 1ns/100ps

module dma_data_fifo (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                push,
	input  logic                pop,
	input  dma_pkg::bus_data_t  wdata,
	output dma_pkg::bus_data_t  rdata,
	output dma_pkg::fifo_cnt_t  count
);

	localparam int PTR_W = $clog2(dma_pkg::FIFO_DEPTH);

	dma_pkg::bus_data_t mem [dma_pkg::FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;

	// Head word is visible without a pop
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + 5'(push) - 5'(pop);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= wdata;
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> count != 5'(dma_pkg::FIFO_DEPTH))
		else $error("push into full FIFO");

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> count != '0)
		else $error("pop from empty FIFO");

endmodule

/* dma_read_top.sv */
`timescale 1ns/100ps

module dma_read_top (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 reg_valid,
	input  logic                 reg_write,
	input  dma_pkg::reg_addr_t   reg_addr,
	input  dma_pkg::bus_data_t   reg_wdata,
	output dma_pkg::bus_data_t   reg_rdata,
	output logic                 reg_rvalid,
	output logic                 fsabo_valid,
	output dma_pkg::bus_mode_t   fsabo_mode,
	output dma_pkg::bus_did_t    fsabo_did,
	output dma_pkg::bus_did_t    fsabo_subdid,
	output dma_pkg::bus_addr_t   fsabo_addr,
	output dma_pkg::burst_len_t  fsabo_len,
	input  logic                 fsabo_credit,
	input  logic                 fsabi_valid,
	input  dma_pkg::bus_did_t    fsabi_did,
	input  dma_pkg::bus_did_t    fsabi_subdid,
	input  dma_pkg::bus_data_t   fsabi_data
);

	dma_pkg::bus_addr_t start_addr;
	dma_pkg::xfer_len_t start_len;
	dma_pkg::xfer_len_t remaining;
	dma_pkg::fifo_cnt_t fifo_count;
	dma_pkg::bus_data_t fifo_rdata;
	dma_pkg::bus_data_t fifo_wdata;
	logic               start;
	logic               busy;
	logic               fifo_pop;
	logic               fifo_push;

	fsab_req_if u_req_if ();

	assign fsabo_valid  = u_req_if.valid;
	assign fsabo_mode   = u_req_if.mode;
	assign fsabo_did    = u_req_if.did;
	assign fsabo_subdid = u_req_if.subdid;
	assign fsabo_addr   = u_req_if.addr;
	assign fsabo_len    = u_req_if.len;

	dma_regs u_dma_regs (
		.clk        (clk),
		.arst_n     (arst_n),
		.reg_valid  (reg_valid),
		.reg_write  (reg_write),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.busy       (busy),
		.remaining  (remaining),
		.fifo_count (fifo_count),
		.fifo_rdata (fifo_rdata),
		.reg_rdata  (reg_rdata),
		.reg_rvalid (reg_rvalid),
		.start_addr (start_addr),
		.start_len  (start_len),
		.start      (start),
		.fifo_pop   (fifo_pop)
	);

	dma_read_ctrl u_dma_read_ctrl (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.start_addr   (start_addr),
		.start_len    (start_len),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data),
		.fifo_count   (fifo_count),
		.req          (u_req_if.ctrl),
		.busy         (busy),
		.remaining    (remaining),
		.fifo_push    (fifo_push),
		.fifo_wdata   (fifo_wdata)
	);

	dma_data_fifo u_dma_data_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.push   (fifo_push),
		.pop    (fifo_pop),
		.wdata  (fifo_wdata),
		.rdata  (fifo_rdata),
		.count  (fifo_count)
	);

endmodule

/* tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model (
	input  logic                 clk,
	input  logic                 req_valid,
	input  dma_pkg::bus_addr_t   req_addr,
	input  dma_pkg::burst_len_t  req_len,
	output logic                 credit,
	output logic                 rsp_valid,
	output dma_pkg::bus_did_t    rsp_did,
	output dma_pkg::bus_did_t    rsp_subdid,
	output dma_pkg::bus_data_t   rsp_data,
	output int                   foreign_sent
);

	logic [31:0]        rng;
	int                 credit_wait [$];
	dma_pkg::bus_addr_t word_q [$];
	dma_pkg::bus_addr_t word_addr;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial
	begin
		rng          = 32'hc2fa_c9b5;
		credit       = 1'b0;
		rsp_valid    = 1'b0;
		rsp_did      = '0;
		rsp_subdid   = '0;
		rsp_data     = '0;
		foreign_sent = 0;
	end

	always
	begin
		@(posedge clk);
		#0.5;
		rng = xorshift32(rng);
		credit = 1'b0;
		// Credits go back one at a time, oldest request first
		if (credit_wait.size() != 0)
		begin
			if (credit_wait[0] <= 1)
			begin
				credit = 1'b1;
				void'(credit_wait.pop_front());
			end
			else
				credit_wait[0] = credit_wait[0] - 1;
		end
		if (req_valid)
		begin
			credit_wait.push_back(1 + int'(rng[15:8] % 8'd6));
			for (int i = 0; i < int'(req_len); i++)
				word_q.push_back(req_addr + dma_pkg::bus_addr_t'(i));
		end
		rsp_valid  = 1'b0;
		rsp_did    = '0;
		rsp_subdid = '0;
		rsp_data   = '0;
		if (rng[2:0] == 3'd0)
		begin
			// One id wrong, the other right
			rsp_valid    = 1'b1;
			rsp_did      = rng[3] ? dma_pkg::DMA_DID : ~dma_pkg::DMA_DID;
			rsp_subdid   = rng[3] ? ~dma_pkg::DMA_SUBDID : dma_pkg::DMA_SUBDID;
			rsp_data     = {rng, ~rng};
			foreign_sent = foreign_sent + 1;
		end
		else if (word_q.size() != 0 && rng[5:4] != 2'd0)
		begin
			word_addr  = word_q.pop_front();
			rsp_valid  = 1'b1;
			rsp_did    = dma_pkg::DMA_DID;
			rsp_subdid = dma_pkg::DMA_SUBDID;
			rsp_data   = {word_addr, ~word_addr};
		end
	end

endmodule

/* tb_dma_read.sv */
`timescale 1ns/100ps

module tb_dma_read;

	localparam int POLL_LIMIT = 500;

	logic                 clk;
	logic                 arst_n;
	logic                 reg_valid;
	logic                 reg_write;
	dma_pkg::reg_addr_t   reg_addr;
	dma_pkg::bus_data_t   reg_wdata;
	dma_pkg::bus_data_t   reg_rdata;
	logic                 reg_rvalid;
	logic                 fsabo_valid;
	dma_pkg::bus_mode_t   fsabo_mode;
	dma_pkg::bus_did_t    fsabo_did;
	dma_pkg::bus_did_t    fsabo_subdid;
	dma_pkg::bus_addr_t   fsabo_addr;
	dma_pkg::burst_len_t  fsabo_len;
	logic                 fsabo_credit;
	logic                 fsabi_valid;
	dma_pkg::bus_did_t    fsabi_did;
	dma_pkg::bus_did_t    fsabi_subdid;
	dma_pkg::bus_data_t   fsabi_data;
	int                   foreign_sent;

	int                   errors;
	int                   tests_run;
	int                   tests_failed;
	// Words pushed and popped as seen at each rising edge
	int                   pushed;
	int                   popped;
	int                   popped_prev;
	int                   requested;
	int                   unreturned;
	int                   burst_exp;
	int                   xfer_reqs;
	int                   xfer_words;
	int                   exp_req_rem;
	int                   last_rem;
	dma_pkg::bus_addr_t   exp_req_addr;
	dma_pkg::bus_addr_t   exp_data_addr;

	dma_read_top u_dma_read_top (
		.clk          (clk),
		.arst_n       (arst_n),
		.reg_valid    (reg_valid),
		.reg_write    (reg_write),
		.reg_addr     (reg_addr),
		.reg_wdata    (reg_wdata),
		.reg_rdata    (reg_rdata),
		.reg_rvalid   (reg_rvalid),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	tb_mem_model u_mem_model (
		.clk          (clk),
		.req_valid    (fsabo_valid),
		.req_addr     (fsabo_addr),
		.req_len      (fsabo_len),
		.credit       (fsabo_credit),
		.rsp_valid    (fsabi_valid),
		.rsp_did      (fsabi_did),
		.rsp_subdid   (fsabi_subdid),
		.rsp_data     (fsabi_data),
		.foreign_sent (foreign_sent)
	);

	initial
		clk = 1'b0;

	always #2 clk = ~clk;

	function automatic void note_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0.1f ns: %s", $realtime, msg);
	endfunction

	function automatic void note_failure(input string msg);
		errors++;
		$display("Error at %0.1f ns: %s", $realtime, msg);
	endfunction

	// Memory data: address in the high half, inverted address in the low half
	function automatic dma_pkg::bus_data_t expected_word(input dma_pkg::bus_addr_t a);
		return {a, ~a};
	endfunction

	always @(posedge clk)
	begin
		if (arst_n)
		begin
			if (fsabo_valid)
			begin
				burst_exp = (exp_req_rem < dma_pkg::MAX_BURST) ? exp_req_rem : dma_pkg::MAX_BURST;
				assert (fsabo_addr == exp_req_addr && int'(fsabo_len) == burst_exp)
				else note_mismatch($sformatf("request addr %h len %0d, expected addr %h len %0d",
					fsabo_addr, fsabo_len, exp_req_addr, burst_exp));
				exp_req_addr = exp_req_addr + dma_pkg::bus_addr_t'(burst_exp);
				exp_req_rem  = exp_req_rem - burst_exp;
				requested    = requested + int'(fsabo_len);
				unreturned   = unreturned + 1;
				xfer_reqs    = xfer_reqs + 1;
				// Controller saw pops only up to the edge before it issued
				assert (requested - popped_prev <= dma_pkg::FIFO_DEPTH)
				else note_mismatch("request overruns the reserved FIFO space");
			end
			if (fsabo_credit)
				unreturned = unreturned - 1;
			popped_prev = popped;
			if (reg_valid && !reg_write && reg_addr == dma_pkg::REG_DATA && pushed > popped)
				popped = popped + 1;
			if (fsabi_valid && fsabi_did == dma_pkg::DMA_DID &&
				fsabi_subdid == dma_pkg::DMA_SUBDID)
				pushed = pushed + 1;
		end
	end

	a_req_fields: assert property (@(posedge clk) disable iff (!arst_n)
		fsabo_valid |-> (fsabo_mode == dma_pkg::MODE_READ && fsabo_did == dma_pkg::DMA_DID &&
			fsabo_subdid == dma_pkg::DMA_SUBDID))
		else note_mismatch("request mode or ids wrong");

	a_credit_window: assert property (@(posedge clk) disable iff (!arst_n)
		unreturned <= dma_pkg::CREDITS_INIT)
		else note_mismatch("more requests outstanding than credits granted");

	a_reset_state: assert property (@(posedge clk)
		!arst_n |-> (!fsabo_valid && !reg_rvalid))
		else note_mismatch("request or read response active in reset");

	task automatic write_reg(input dma_pkg::reg_addr_t a, input dma_pkg::bus_data_t d);
		reg_valid = 1'b1;
		reg_write = 1'b1;
		reg_addr  = a;
		reg_wdata = d;
		@(posedge clk);
		#0.5;
		reg_valid = 1'b0;
		reg_write = 1'b0;
	endtask

	task automatic read_reg(input dma_pkg::reg_addr_t a, output dma_pkg::bus_data_t d);
		int waited;
		waited    = 0;
		reg_valid = 1'b1;
		reg_write = 1'b0;
		reg_addr  = a;
		do
		begin
			@(posedge clk);
			#0.5;
			reg_valid = 1'b0;
			waited++;
		end
		while (!reg_rvalid && waited < 4);
		assert (reg_rvalid && waited == 1)
		else note_failure("register read response did not come one cycle after the read");
		d = reg_rdata;
	endtask

	task automatic read_status(output logic busy, output int cnt, output int rem);
		dma_pkg::bus_data_t d;
		int                 level;
		level = pushed - popped;
		read_reg(dma_pkg::REG_STATUS, d);
		busy = d[0];
		cnt  = int'(d[dma_pkg::STATUS_CNT_LSB +: 5]);
		rem  = int'(d[dma_pkg::STATUS_REM_LSB +: 16]);
		assert (cnt == level)
		else note_mismatch($sformatf("FIFO count %0d, expected %0d", cnt, level));
		assert (rem <= exp_req_rem)
		else note_mismatch($sformatf("remaining %0d above unrequested %0d", rem, exp_req_rem));
		if (busy)
		begin
			assert (rem <= last_rem)
			else note_mismatch($sformatf("remaining grew from %0d to %0d", last_rem, rem));
			last_rem = rem;
		end
	endtask

	task automatic pop_word(output bit got);
		dma_pkg::bus_data_t d;
		dma_pkg::bus_data_t exp;
		got = (pushed > popped);
		exp = got ? expected_word(exp_data_addr) : '0;
		read_reg(dma_pkg::REG_DATA, d);
		assert (d == exp)
		else note_mismatch($sformatf("data word %h, expected %h", d, exp));
		if (got)
		begin
			exp_data_addr = exp_data_addr + 32'd1;
			xfer_words++;
		end
	endtask

	task automatic start_transfer(input dma_pkg::bus_addr_t base, input int len);
		exp_req_addr  = base;
		exp_req_rem   = len;
		exp_data_addr = base;
		xfer_reqs     = 0;
		xfer_words    = 0;
		last_rem      = len;
		write_reg(dma_pkg::REG_ADDR, 64'(base));
		write_reg(dma_pkg::REG_LEN, 64'(len));
		write_reg(dma_pkg::REG_CTRL, 64'd1);
	endtask

	task automatic wait_idle(input string what);
		logic busy;
		int   cnt;
		int   rem;
		int   polls;
		polls = 0;
		do
		begin
			read_status(busy, cnt, rem);
			polls++;
		end
		while ((busy || exp_req_rem != 0) && polls < POLL_LIMIT);
		if (busy || exp_req_rem != 0)
			note_failure({"timeout waiting for ", what, " to finish"});
	endtask

	task automatic drain_words(input int n);
		bit   got;
		logic busy;
		int   cnt;
		int   rem;
		int   tries;
		tries = 0;
		while (xfer_words < n && tries < POLL_LIMIT)
		begin
			pop_word(got);
			if (tries % 4 == 3)
				read_status(busy, cnt, rem);
			tries++;
		end
		if (xfer_words < n)
			note_failure("timeout while popping transfer data");
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: failed", name);
		end
	endtask

	initial
	begin
		int                 err_before;
		int                 polls;
		int                 cnt;
		int                 rem;
		logic               busy;
		bit                 got;
		dma_pkg::bus_data_t d;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		pushed        = 0;
		popped        = 0;
		popped_prev   = 0;
		requested     = 0;
		unreturned    = 0;
		xfer_reqs     = 0;
		xfer_words    = 0;
		exp_req_rem   = 0;
		last_rem      = 0;
		exp_req_addr  = '0;
		exp_data_addr = '0;
		arst_n        = 1'b0;
		reg_valid     = 1'b0;
		reg_write     = 1'b0;
		reg_addr      = '0;
		reg_wdata     = '0;
		repeat (3) @(posedge clk);
		#0.5;
		arst_n = 1'b1;

		err_before = errors;
		read_reg(dma_pkg::REG_STATUS, d);
		assert (d == '0) else note_mismatch($sformatf("status after reset %h", d));
		write_reg(dma_pkg::REG_ADDR, 64'hdead_beef);
		write_reg(dma_pkg::REG_LEN, 64'h1234);
		read_reg(dma_pkg::REG_ADDR, d);
		assert (d == 64'hdead_beef) else note_mismatch($sformatf("address reads %h", d));
		read_reg(dma_pkg::REG_LEN, d);
		assert (d == 64'h1234) else note_mismatch($sformatf("length reads %h", d));
		finish_test("reset and register round trip", err_before);

		err_before = errors;
		start_transfer(32'h0000_1000, 5);
		wait_idle("short transfer");
		assert (xfer_reqs == 1) else note_mismatch($sformatf("%0d requests for 5 words", xfer_reqs));
		drain_words(5);
		pop_word(got);
		assert (!got) else note_mismatch("FIFO not empty after five pops");
		finish_test("short transfer", err_before);

		err_before = errors;
		start_transfer(32'h0000_2000, 20);
		drain_words(20);
		wait_idle("long transfer");
		assert (xfer_reqs == 3) else note_mismatch($sformatf("%0d requests for 20 words", xfer_reqs));
		finish_test("long transfer with credit limits", err_before);

		err_before = errors;
		start_transfer(32'h0000_3000, 40);
		polls = 0;
		cnt   = 0;
		while (cnt < dma_pkg::FIFO_DEPTH && polls < POLL_LIMIT)
		begin
			read_status(busy, cnt, rem);
			polls++;
		end
		if (cnt < dma_pkg::FIFO_DEPTH)
			note_failure("timeout waiting for the FIFO to fill");
		assert (busy && rem > 0) else note_mismatch("transfer not stalled with words left");
		drain_words(40);
		wait_idle("back-pressure transfer");
		finish_test("FIFO back-pressure", err_before);

		err_before = errors;
		polls = foreign_sent;
		start_transfer(32'h0000_4000, 12);
		wait_idle("transfer with foreign responses");
		read_status(busy, cnt, rem);
		assert (cnt == 12) else note_mismatch($sformatf("FIFO count %0d, expected 12", cnt));
		drain_words(12);
		if (foreign_sent <= polls)
			note_failure("no foreign responses were injected during the transfer");
		finish_test("foreign responses", err_before);

		err_before = errors;
		start_transfer(32'h0000_5000, 30);
		polls = 0;
		busy  = 1'b0;
		while (!busy && polls < POLL_LIMIT)
		begin
			read_status(busy, cnt, rem);
			polls++;
		end
		if (!busy)
			note_failure("engine never became busy");
		write_reg(dma_pkg::REG_CTRL, 64'd1);
		drain_words(30);
		wait_idle("restarted transfer");
		assert (xfer_reqs == 4) else note_mismatch($sformatf("%0d requests for 30 words", xfer_reqs));
		finish_test("start while busy", err_before);

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
dma_pkg.sv
fsab_req_if.sv
dma_regs.sv
dma_read_ctrl.sv
dma_data_fifo.sv
dma_read_top.sv
tb_mem_model.sv
tb_dma_read.sv

/* run.sh */
#!/bin/sh
# Build and run the DMA read testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_dma_read -f all.f -o sim_dma_read
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_dma_read)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
